//--- src/hold_stage.sv
// One-entry holding register with valid/ready handshake on its input and output sides

`timescale 1ns/1ns

module hold_stage #(
   parameter type payload_t = logic
) (
   input  logic     clk4,
   input  logic     arst_n,
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data
);

   // Occupancy flag of the single entry
   logic     full;

   // Stored payload
   payload_t data_q;

   //////////////////////////////
   // Input side
   //////////////////////////////

   // The entry can take new data when it is empty or when its present
   // content leaves in this same cycle
   // Under a steady out_ready this passes one item per clock
   assign in_ready = !full || out_ready;

   // The flag follows the input valid whenever the stage is able to move
   // An empty input with the old item taken leaves the entry empty
   always_ff @(posedge clk4 or negedge arst_n) begin
      if (!arst_n) begin
         full <= 1'b0;
      end else if (in_ready) begin
         full <= in_valid;
      end
   end

   // Payload is only written on a real input transfer
   // A stalled entry keeps its word stable until it is taken
   always_ff @(posedge clk4) begin
      if (in_valid && in_ready) begin
         data_q <= in_data;
      end
   end

   //////////////////////////////
   // Output side
   //////////////////////////////

   assign out_valid = full;
   assign out_data  = data_q;

endmodule

//--- src/ucode_pkg.sv
// Microcode control unit package with widths, opcode and micro-op types and the program length rule

package ucode_pkg;

   //////////////////////////////
   // Widths
   //////////////////////////////

   // Width of the micro-program counter
   localparam int UPC_W = 4;

   // Width of an instruction opcode
   localparam int OPC_W = 4;

   // Width of the datapath control field carried by each micro-op
   localparam int CTRL_W = 8;

   // Opcode bits that select the program length
   // Every opcode runs one to four micro-steps, so two bits are enough
   localparam int LEN_BITS = 2;

   //////////////////////////////
   // Types
   //////////////////////////////

   // A bare instruction opcode as it arrives from the instruction source
   typedef logic [OPC_W-1:0] opcode_t;

   // One micro-op word as handed to the datapath
   // The word names its own opcode and step so that a consumer can tell
   // which instruction and which micro-step it belongs to
   typedef struct packed {
      logic                last;
      opcode_t             op;
      logic [UPC_W-1:0]    step;
      logic [CTRL_W-1:0]   ctrl;
   } uop_t;

   //////////////////////////////
   // Microprogram length rule
   //////////////////////////////

   // Final micro-step of an opcode's program
   // Opcode k runs (k mod 4) + 1 steps, numbered from zero, so the last
   // step is simply the low two opcode bits
   function automatic logic [UPC_W-1:0] last_step(input opcode_t op);
      logic [UPC_W-1:0] result;
      result = '0;
      result[LEN_BITS-1:0] = op[LEN_BITS-1:0];
      return result;
   endfunction

endpackage

//--- src/ucode_rom.sv
// Combinational microcode store returning the micro-op word for an opcode and micro-step

`timescale 1ns/1ns

module ucode_rom (
   input  ucode_pkg::opcode_t          op,
   input  logic [ucode_pkg::UPC_W-1:0] upc,
   output ucode_pkg::uop_t             word
);

   // Control pattern of the opcode before any rotation
   // Upper nibble is the opcode and the lower nibble its inverse
   logic [ucode_pkg::CTRL_W-1:0] pattern;

   // Pattern rotated left by the current micro-step
   logic [ucode_pkg::CTRL_W-1:0] rotated;

   // Final micro-step of this opcode's program
   logic [ucode_pkg::UPC_W-1:0]  final_step;

   // Address lies inside the opcode's program
   logic                         in_range;

   assign pattern    = {op, ~op};
   assign final_step = ucode_pkg::last_step(op);
   assign in_range   = (upc <= final_step);

   //////////////////////////////
   // Step table
   //////////////////////////////

   // Each micro-step rotates the control pattern one more place to the left
   // No program is longer than four steps, so only four rows hold data
   always_comb begin
      case (upc)
         4'd0: begin
            rotated = pattern;
         end
         4'd1: begin
            rotated = {pattern[6:0], pattern[7]};
         end
         4'd2: begin
            rotated = {pattern[5:0], pattern[7:6]};
         end
         4'd3: begin
            rotated = {pattern[4:0], pattern[7:5]};
         end
         default: begin
            // Steps four and above are never part of a program
            rotated = '0;
         end
      endcase
   end

   //////////////////////////////
   // Word assembly
   //////////////////////////////

   // The word always carries its own opcode and step
   always_comb begin
      word.op   = op;
      word.step = upc;
      if (in_range) begin
         // The end marker sits on the final step of the program only
         word.last = (upc == final_step);
         word.ctrl = rotated;
      end else begin
         // Past the end of the program the store returns an empty word
         // that ends the instruction at once
         word.last = 1'b1;
         word.ctrl = '0;
      end
   end

endmodule

//--- src/ucode_sequencer.sv
// Microcode sequencer that issues micro-ops, steers the micro-program counter and retires instructions

`timescale 1ns/1ns

module ucode_sequencer (
   input  logic            instr_valid,
   output logic            instr_ready,
   input  ucode_pkg::uop_t rom_word,
   input  logic            halt,
   input  logic            end_ext,
   output logic            count,
   output logic            clear,
   output logic            issue_valid,
   input  logic            issue_ready,
   output ucode_pkg::uop_t issue_word
);

   // A micro-op leaves for the output stage in this cycle
   logic fire;

   // The micro-op on offer ends its instruction
   // Either the store marks it as the final step or the end request is up
   logic end_now;

   //////////////////////////////
   // Issue
   //////////////////////////////

   // A micro-op is on offer whenever an instruction is held and the
   // processor is not halted
   // Halt freezes the whole sequence and offers nothing
   assign issue_valid = instr_valid && !halt;

   // The output stage decides whether the offer is taken
   // A low issue_ready is a wait state pushed back from the datapath
   assign fire = issue_valid && issue_ready;

   // The external end request is merged into the end marker
   // It only has an effect through fire, so it is ignored in cycles that
   // issue nothing
   assign end_now = rom_word.last || end_ext;

   // The word from the store passes through with the merged end marker
   // so that the datapath sees where the instruction stops
   always_comb begin
      issue_word      = rom_word;
      issue_word.last = end_now;
   end

   //////////////////////////////
   // Counter control
   //////////////////////////////

   // Both requests are qualified by fire
   // A halted or waiting cycle therefore asks for nothing and the counter
   // holds, which also keeps an end seen during a wait from clearing it
   assign count = fire && !end_now;
   assign clear = fire && end_now;

   //////////////////////////////
   // Retire
   //////////////////////////////

   // The instruction is done once its final micro-op has left
   // Popping the instruction stage in that same cycle lets the next
   // opcode move in without a bubble
   assign instr_ready = fire && end_now;

endmodule

//--- src/ucode_top.sv
// Microcode control unit top level joining the instruction stage, sequencer, counter, store and output stage

`timescale 1ns/1ns

module ucode_top (
   input  logic               clk4,
   input  logic               arst_n,
   input  logic               instr_valid,
   output logic               instr_ready,
   input  ucode_pkg::opcode_t instr_op,
   input  logic               halt,
   input  logic               end_ext,
   output logic               uop_valid,
   input  logic               uop_ready,
   output ucode_pkg::uop_t    uop_word
);

   // Opcode held for sequencing and its handshake to the sequencer
   ucode_pkg::opcode_t          held_op;
   logic                        held_valid;
   logic                        retire;

   // Counter control and value
   logic                        upc_count;
   logic                        upc_clear;
   logic [ucode_pkg::UPC_W-1:0] upc;

   // Word read from the store
   ucode_pkg::uop_t             rom_word;

   // Micro-op handed to the output stage
   logic                        issue_valid;
   logic                        issue_ready;
   ucode_pkg::uop_t             issue_word;

   //////////////////////////////
   // Instruction stage
   //////////////////////////////

   // Holds the opcode for the whole of its microprogram
   // It is popped by the sequencer when the final micro-op leaves
   hold_stage #(
      .payload_t (ucode_pkg::opcode_t)
   ) instr_stage (
      .clk4      (clk4),
      .arst_n    (arst_n),
      .in_valid  (instr_valid),
      .in_ready  (instr_ready),
      .in_data   (instr_op),
      .out_valid (held_valid),
      .out_ready (retire),
      .out_data  (held_op)
   );

   //////////////////////////////
   // Sequencing
   //////////////////////////////

   ucode_sequencer sequencer (
      .instr_valid (held_valid),
      .instr_ready (retire),
      .rom_word    (rom_word),
      .halt        (halt),
      .end_ext     (end_ext),
      .count       (upc_count),
      .clear       (upc_clear),
      .issue_valid (issue_valid),
      .issue_ready (issue_ready),
      .issue_word  (issue_word)
   );

   upc_counter upc_ctr (
      .clk4   (clk4),
      .arst_n (arst_n),
      .count  (upc_count),
      .clear  (upc_clear),
      .upc    (upc)
   );

   // The store is addressed by the held opcode and the current micro-step
   ucode_rom rom (
      .op   (held_op),
      .upc  (upc),
      .word (rom_word)
   );

   //////////////////////////////
   // Output stage
   //////////////////////////////

   // The first micro-op of an opcode captured at one edge is written here
   // at the next edge, and the datapath can take it at the edge after that
   hold_stage #(
      .payload_t (ucode_pkg::uop_t)
   ) uop_stage (
      .clk4      (clk4),
      .arst_n    (arst_n),
      .in_valid  (issue_valid),
      .in_ready  (issue_ready),
      .in_data   (issue_word),
      .out_valid (uop_valid),
      .out_ready (uop_ready),
      .out_data  (uop_word)
   );

endmodule

//--- src/upc_counter.sv
// Micro-program counter that steps through one instruction's micro-ops and clears on end

`timescale 1ns/1ns

module upc_counter (
   input  logic                       clk4,
   input  logic                       arst_n,
   input  logic                       count,
   input  logic                       clear,
   output logic [ucode_pkg::UPC_W-1:0] upc
);

   // The counter works like a loadable binary counter whose load value is
   // tied to zero
   // Loading (here the clear) beats counting when both are requested
   //
   // Halt and wait gating is not tested here
   // The sequencer only raises count or clear in a cycle in which a micro-op
   // really leaves, so a stalled or halted cycle arrives with both low and
   // the count simply holds
   //
   // An end seen during a wait state therefore never clears the count
   // early, and the step that was stalled is issued again once the datapath
   // takes it

   //////////////////////////////
   // Counter register
   //////////////////////////////

   always_ff @(posedge clk4 or negedge arst_n) begin
      if (!arst_n) begin
         // Every instruction starts at micro-step zero
         upc <= '0;
      end else if (clear) begin
         // Final micro-op issued, next instruction begins at step zero
         upc <= '0;
      end else if (count) begin
         upc <= upc + 1'b1;
      end
   end

   // With no request the count keeps its value
   // This is the frozen state seen while halted or waiting

endmodule

//--- tb/ucode_model.svh
// Reference model of the microprogram giving the expected control field and program length

`ifndef UCODE_MODEL_SVH
`define UCODE_MODEL_SVH

//////////////////////////////
// Program length
//////////////////////////////

// Number of micro-ops in the program of opcode k
function automatic int program_length(input logic [3:0] op);
   return (op % 4) + 1;
endfunction

// Step on which the end marker must appear
function automatic int final_step_of(input logic [3:0] op);
   return program_length(op) - 1;
endfunction

//////////////////////////////
// Control field
//////////////////////////////

// Start from the opcode over its inverse and rotate left once per step
// The pattern turns by one bit for every step
function automatic logic [7:0] expected_ctrl(input logic [3:0] op, input int step);
   logic [7:0] value;
   int         i;
   value = {op, ~op};
   for (i = 0; i < step; i++) begin
      // Top bit wraps round to the bottom
      value = {value[6:0], value[7]};
   end
   return value;
endfunction

`endif

//--- tb/ucode_tb.sv
// Testbench for the microcode control unit with random stimulus checked against a program model

`timescale 1ns/1ns

module ucode_tb;

   logic               clk4;
   logic               arst_n;
   logic               instr_valid;
   logic               instr_ready;
   ucode_pkg::opcode_t instr_op;
   logic               halt;
   logic               end_ext;
   logic               uop_valid;
   logic               uop_ready;
   ucode_pkg::uop_t    uop_word;

   // Random state, accepted opcodes and monitor bookkeeping
   integer             seed;
   logic [3:0]         op_q[$];
   int                 exp_step, last_len, cycle, accept_cycle, first_cycle, last_cycle;
   int                 errors, checked, retired, tests_run;
   bit                 instr_took, end_window, stalled, halt_idle;
   ucode_pkg::uop_t    stall_word;

   `include "ucode_model.svh"

   ucode_top UUT (
      .clk4 (clk4), .arst_n (arst_n),
      .instr_valid (instr_valid), .instr_ready (instr_ready), .instr_op (instr_op),
      .halt (halt), .end_ext (end_ext),
      .uop_valid (uop_valid), .uop_ready (uop_ready), .uop_word (uop_word)
   );

   always #20 clk4 = ~clk4;

   task automatic report_error(input string msg);
      $display("[ERROR] %0t ns: %s", $time, msg);
      errors++;
   endtask

   function automatic bit chance(input int pct);
      return ($unsigned($random(seed)) % 100) < pct;
   endfunction

   //////////////////////////////
   // Monitor
   //////////////////////////////

   // Compare one transferred micro-op with the head of the opcode queue
   task automatic check_word(input ucode_pkg::uop_t w);
      int fin;
      checked++;
      if (op_q.size() == 0) begin
         report_error("micro-op transferred with no accepted instruction");
         return;
      end
      fin = final_step_of(op_q[0]);
      if (w.op != op_q[0])
         report_error($sformatf("opcode %0h expected, got %0h", op_q[0], w.op));
      if (w.step != exp_step)
         report_error($sformatf("step %0d expected, got %0d", exp_step, w.step));
      if (w.ctrl != expected_ctrl(op_q[0], exp_step))
         report_error($sformatf("ctrl %h expected, got %h",
                                expected_ctrl(op_q[0], exp_step), w.ctrl));
      if (exp_step == fin && !w.last)
         report_error("last missing on the final step");
      // An early end is only legal if the end request was up at some
      // edge while this word could have been issued
      if (w.last && exp_step < fin && !end_window)
         report_error("last set early with no end request");
      if (exp_step == 0)
         first_cycle = cycle;
      if (w.last || exp_step >= fin) begin
         last_len = exp_step + 1;
         last_cycle = cycle;
         void'(op_q.pop_front());
         exp_step = 0;
         retired++;
      end else begin
         exp_step++;
      end
   endtask

   // Everything is sampled at the rising edge, half a cycle after inputs moved
   always @(posedge clk4) begin
      if (arst_n) begin
         cycle++;
         // A stalled word must stay put until it is taken
         if (stalled && (!uop_valid || uop_word != stall_word))
            report_error("output word changed while stalled");
         // Halted with an empty output stage means nothing can appear
         if (halt_idle && uop_valid)
            report_error("micro-op issued while halted");
         if (uop_valid && uop_ready) begin
            check_word(uop_word);
            // The window for the next word opens at this edge
            end_window = end_ext;
         end else begin
            end_window = end_window || end_ext;
         end
         instr_took = instr_valid && instr_ready;
         if (instr_took) begin
            op_q.push_back(instr_op);
            accept_cycle = cycle;
         end
         stalled    = uop_valid && !uop_ready;
         stall_word = uop_word;
         halt_idle  = halt && !uop_valid;
      end
   end

   //////////////////////////////
   // Stimulus tasks
   //////////////////////////////

   // Idle the inputs and wait until every accepted opcode has retired
   task automatic drain(input string what);
      int i;
      bit done;
      done = 0;
      for (i = 0; i < 200 && !done; i++) begin
         @(negedge clk4);
         halt      = 0;
         end_ext   = 0;
         uop_ready = 1;
         // An offered opcode stays up until it is taken
         if (instr_took)
            instr_valid = 0;
         done = !instr_valid && op_q.size() == 0 && !uop_valid;
      end
      if (!done)
         report_error($sformatf("%s did not drain, %0d opcodes left", what, op_q.size()));
   endtask

   task automatic run_random(input int cycles, input int p_valid, input int p_ready,
                             input int p_halt, input int p_end);
      int i;
      for (i = 0; i < cycles; i++) begin
         @(negedge clk4);
         if (!instr_valid || instr_took) begin
            instr_valid = chance(p_valid);
            instr_op    = $random(seed);
         end
         uop_ready = chance(p_ready);
         halt      = chance(p_halt);
         end_ext   = chance(p_end);
      end
   endtask

   // Every opcode alone at full rate, checking length, spacing and first latency
   task automatic full_rate;
      int  k, i;
      bit  took;
      uop_ready = 1;
      halt      = 0;
      end_ext   = 0;
      for (k = 0; k < 16; k++) begin
         @(negedge clk4);
         instr_valid = 1;
         instr_op    = k;
         took = 0;
         for (i = 0; i < 20 && !took; i++) begin
            @(negedge clk4);
            took = instr_took;
         end
         instr_valid = 0;
         if (!took) begin
            $display("Opcode %0d was never accepted", k);
            errors++;
         end
         drain("full rate instruction");
         if (last_len != program_length(k))
            report_error($sformatf("opcode %0d gave %0d micro-ops", k, last_len));
         if (first_cycle - accept_cycle != 2)
            report_error($sformatf("first micro-op %0d edges after acceptance",
                                   first_cycle - accept_cycle));
         // Under a steady ready one micro-op leaves on every edge
         if (last_cycle - first_cycle != program_length(k) - 1)
            report_error($sformatf("opcode %0d micro-ops spread over %0d edges",
                                   k, last_cycle - first_cycle + 1));
      end
   endtask

   task automatic finish_test(input string name, input int errs_before);
      tests_run++;
      $display("Test %s finished with %0d errors", name, errors - errs_before);
   endtask

   //////////////////////////////
   // Test sequence
   //////////////////////////////

   initial begin : main
      int  i;
      int  e;
      seed = 89;
      clk4 = 0;
      arst_n = 0;
      instr_valid = 0;
      instr_op = '0;
      halt = 0;
      end_ext = 0;
      uop_ready = 0;
      {errors, checked, retired, tests_run, cycle, exp_step} = '0;
      {instr_took, end_window, stalled, halt_idle} = '0;

      e = errors;
      for (i = 0; i < 6; i++) begin
         @(negedge clk4);
         if (i == 4)
            arst_n = 1;
         if (uop_valid || !instr_ready)
            report_error("uop_valid high or instr_ready low around reset");
      end
      finish_test("reset state", e);

      e = errors;
      full_rate();
      finish_test("full rate sequence", e);

      e = errors;
      run_random(500, 70, 60, 0, 0);
      drain("wait state run");
      finish_test("wait states", e);

      e = errors;
      run_random(500, 70, 100, 10, 0);
      drain("halt run");
      finish_test("halt", e);

      e = errors;
      run_random(500, 70, 100, 0, 5);
      drain("end request run");
      finish_test("external end", e);

      e = errors;
      run_random(2000, 70, 60, 10, 5);
      drain("mixed load run");
      finish_test("ordering under load", e);

      $display("Tests %0d, micro-ops checked %0d, instructions retired %0d, errors %0d",
               tests_run, checked, retired, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

//--- ucode_top.f
+incdir+tb
src/ucode_pkg.sv
src/upc_counter.sv
src/hold_stage.sv
src/ucode_rom.sv
src/ucode_sequencer.sv
src/ucode_top.sv
tb/ucode_tb.sv
